//--- common/rename_pkg.sv
package rename_pkg;

    // ========================================
    // Register file sizes
    // ========================================

    localparam int num_gprs  = 32;                  // Architectural integer registers
    localparam int num_pregs = 64;                  // Physical integer registers
    localparam int num_free  = num_pregs - num_gprs;
    localparam int num_wb    = 2;                   // Write-back ports

    localparam int gpr_id_w   = $clog2(num_gprs);
    localparam int prf_id_w   = $clog2(num_pregs);
    localparam int free_ptr_w = $clog2(num_free);

    // ========================================
    // Id types
    // ========================================

    typedef logic [gpr_id_w-1:0]   t_gpr_id;        // x0..x31
    typedef logic [prf_id_w-1:0]   t_prf_id;        // p0..p63
    typedef logic [free_ptr_w-1:0] t_free_ptr;      // Free list head and tail

    // Operand kind as given by decode.
    // Only op_reg operands touch the alias table
    typedef enum logic [1:0] {
        op_none = 2'd0,
        op_reg  = 2'd1,
        op_imm  = 2'd2
    } t_optype;

endpackage

//--- rename/rename_ctl.sv
`timescale 1ns/1ns

module rename_ctl
    import rename_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_rn0,
    input  logic     alloc_ready_ra0,
    input  t_optype  dst_type_rn0,
    input  t_gpr_id  dst_gpr_rn0,

    input  logic     free_avail_rn0,

    output logic     fire_rn0,
    output logic     alloc_rn0,
    output logic     rename_ready_rn0,

    output logic     valid_rn1,
    output logic     pdst_vld_rn1,

    input  t_prf_id  pdst_new_rn1,
    input  t_prf_id  pdst_old_map_rn1,
    output t_prf_id  pdst_rn1,
    output t_prf_id  pdst_old_rn1
);

    // ========================================
    // RN0 accept
    // ========================================

    // Stall on an empty free list even for micro-ops that need no pdst
    assign rename_ready_rn0 = free_avail_rn0;

    assign fire_rn0 = valid_rn0 & rename_ready_rn0 & alloc_ready_ra0;

    assign alloc_rn0 = fire_rn0
                     & (dst_type_rn0 == op_reg)
                     & (dst_gpr_rn0 != '0);         // x0 is never renamed

    // ========================================
    // RN1 output
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_rn1    <= 1'b0;
            pdst_vld_rn1 <= 1'b0;
        end else begin
            valid_rn1    <= fire_rn0;
            pdst_vld_rn1 <= alloc_rn0;
        end
    end

    assign pdst_rn1     = pdst_vld_rn1 ? pdst_new_rn1     : '0;  // Zero when nothing allocated
    assign pdst_old_rn1 = pdst_vld_rn1 ? pdst_old_map_rn1 : '0;

endmodule

//--- rename/rename_rat.sv
`timescale 1ns/1ns

module rename_rat
    import rename_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     fire_rn0,
    input  logic     alloc_rn0,

    input  t_gpr_id  dst_gpr_rn0,
    input  t_prf_id  pdst_new_rn0,

    input  t_optype  src1_type_rn0,
    input  t_gpr_id  src1_gpr_rn0,
    input  t_optype  src2_type_rn0,
    input  t_gpr_id  src2_gpr_rn0,

    input  logic     wb_en_ro0   [num_wb-1:0],
    input  t_prf_id  wb_preg_ro0 [num_wb-1:0],

    output t_prf_id  psrc1_rn1,
    output t_prf_id  psrc2_rn1,
    output t_prf_id  pdst_old_map_rn1,
    output logic     psrc1_pend_rn1,
    output logic     psrc2_pend_rn1
);

    t_prf_id               map [num_gprs-1:0];      // gpr -> preg
    logic [num_pregs-1:0]  pend;                    // Set at allocate, cleared at write-back
    logic [num_pregs-1:0]  pend_nxt;
    logic [num_pregs-1:0]  wb_clr;

    logic     src1_live_rn0;
    logic     src2_live_rn0;
    logic     src1_live_rn1;
    logic     src2_live_rn1;
    t_prf_id  psrc1_rn0;
    t_prf_id  psrc2_rn0;

    // ========================================
    // RN0 lookup
    // ========================================

    assign src1_live_rn0 = (src1_type_rn0 == op_reg) & (src1_gpr_rn0 != '0);
    assign src2_live_rn0 = (src2_type_rn0 == op_reg) & (src2_gpr_rn0 != '0);

    assign psrc1_rn0 = src1_live_rn0 ? map[src1_gpr_rn0] : '0;  // x0 and imm read p0
    assign psrc2_rn0 = src2_live_rn0 ? map[src2_gpr_rn0] : '0;

    // ========================================
    // Pending bits
    // ========================================

    always_comb begin
        wb_clr = '0;
        for (int i = 0; i < num_wb; i++) begin
            if (wb_en_ro0[i]) begin
                wb_clr[wb_preg_ro0[i]] = 1'b1;
            end
        end
    end

    always_comb begin
        pend_nxt = pend & ~wb_clr;
        if (alloc_rn0) begin
            pend_nxt[pdst_new_rn0] = 1'b1;          // Fresh pdst waits for its result
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_gprs; i++) begin
                map[i] <= t_prf_id'(i);             // Identity mapping
            end
            pend <= '0;
        end else begin
            pend <= pend_nxt;
            if (alloc_rn0) begin
                map[dst_gpr_rn0] <= pdst_new_rn0;
            end
        end
    end

    // ========================================
    // RN1 output
    // ========================================

    // Sources sample the map before this micro-op's own write lands
    always_ff @(posedge clk) begin
        if (reset) begin
            psrc1_rn1        <= '0;
            psrc2_rn1        <= '0;
            pdst_old_map_rn1 <= '0;
            src1_live_rn1    <= 1'b0;
            src2_live_rn1    <= 1'b0;
        end else if (fire_rn0) begin
            psrc1_rn1        <= psrc1_rn0;
            psrc2_rn1        <= psrc2_rn0;
            pdst_old_map_rn1 <= map[dst_gpr_rn0];
            src1_live_rn1    <= src1_live_rn0;
            src2_live_rn1    <= src2_live_rn0;
        end
    end

    assign psrc1_pend_rn1 = src1_live_rn1 & pend[psrc1_rn1] & ~wb_clr[psrc1_rn1];  // WB bypass
    assign psrc2_pend_rn1 = src2_live_rn1 & pend[psrc2_rn1] & ~wb_clr[psrc2_rn1];

endmodule

//--- rename/rename_free_list.sv
`timescale 1ns/1ns

module rename_free_list
    import rename_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     alloc_rn0,

    input  logic     reclaim_en_rb1,
    input  t_prf_id  reclaim_preg_rb1,

    output logic     free_avail_rn0,
    output t_prf_id  pdst_new_rn0,
    output t_prf_id  pdst_new_rn1
);

    t_prf_id                  fifo [num_free-1:0];
    t_free_ptr                head;
    t_free_ptr                tail;
    logic [free_ptr_w:0]      count;                // 0..num_free
    logic                     push;

    // ========================================
    // Pop side
    // ========================================

    assign free_avail_rn0 = (count != '0);
    assign pdst_new_rn0   = fifo[head];

    always_ff @(posedge clk) begin
        if (alloc_rn0) begin
            pdst_new_rn1 <= pdst_new_rn0;
        end
    end

    // ========================================
    // Push side and pointers
    // ========================================

    // A full list only takes a reclaim when a pop frees a slot
    assign push = reclaim_en_rb1 & ((count != num_free) | alloc_rn0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_free; i++) begin
                fifo[i] <= t_prf_id'(num_gprs + i);  // p32..p63 in order
            end
            head  <= '0;
            tail  <= '0;
            count <= (free_ptr_w+1)'(num_free);
        end else begin
            if (push) begin
                fifo[tail] <= reclaim_preg_rb1;
                tail       <= tail + 1'b1;          // Wraps at num_free
            end
            if (alloc_rn0) begin
                head <= head + 1'b1;
            end
            case ({push, alloc_rn0})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rename/rename.sv
`timescale 1ns/1ns

module rename
    import rename_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  logic     valid_rn0,
    input  t_optype  dst_type_rn0,
    input  t_gpr_id  dst_gpr_rn0,
    input  t_optype  src1_type_rn0,
    input  t_gpr_id  src1_gpr_rn0,
    input  t_optype  src2_type_rn0,
    input  t_gpr_id  src2_gpr_rn0,

    input  logic     alloc_ready_ra0,
    output logic     rename_ready_rn0,

    input  logic     wb_en_ro0   [num_wb-1:0],
    input  t_prf_id  wb_preg_ro0 [num_wb-1:0],

    input  logic     reclaim_en_rb1,
    input  t_prf_id  reclaim_preg_rb1,

    output logic     valid_rn1,
    output logic     pdst_vld_rn1,
    output t_prf_id  pdst_rn1,
    output t_prf_id  pdst_old_rn1,
    output t_prf_id  psrc1_rn1,
    output t_prf_id  psrc2_rn1,
    output logic     psrc1_pend_rn1,
    output logic     psrc2_pend_rn1
);

    logic     fire_rn0;
    logic     alloc_rn0;
    logic     free_avail_rn0;
    t_prf_id  pdst_new_rn0;
    t_prf_id  pdst_new_rn1;
    t_prf_id  pdst_old_map_rn1;

    rename_ctl ctl (
        .clk,
        .reset,
        .valid_rn0,
        .alloc_ready_ra0,
        .dst_type_rn0,
        .dst_gpr_rn0,
        .free_avail_rn0,
        .fire_rn0,
        .alloc_rn0,
        .rename_ready_rn0,
        .valid_rn1,
        .pdst_vld_rn1,
        .pdst_new_rn1,
        .pdst_old_map_rn1,
        .pdst_rn1,
        .pdst_old_rn1
    );

    rename_rat rat (
        .clk,
        .reset,
        .fire_rn0,
        .alloc_rn0,
        .dst_gpr_rn0,
        .pdst_new_rn0,
        .src1_type_rn0,
        .src1_gpr_rn0,
        .src2_type_rn0,
        .src2_gpr_rn0,
        .wb_en_ro0,
        .wb_preg_ro0,
        .psrc1_rn1,
        .psrc2_rn1,
        .pdst_old_map_rn1,
        .psrc1_pend_rn1,
        .psrc2_pend_rn1
    );

    rename_free_list free_list (
        .clk,
        .reset,
        .alloc_rn0,
        .reclaim_en_rb1,
        .reclaim_preg_rb1,
        .free_avail_rn0,
        .pdst_new_rn0,
        .pdst_new_rn1
    );

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // 8 ns period
    end

    // Synchronous reset, high for the first 4 rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- tests/rename_tb.sv
`timescale 1ns/1ns

module rename_tb
    import rename_pkg::*;
();

    logic     clk;
    logic     reset;
    logic     valid_rn0;
    t_optype  dst_type_rn0;
    t_gpr_id  dst_gpr_rn0;
    t_optype  src1_type_rn0;
    t_gpr_id  src1_gpr_rn0;
    t_optype  src2_type_rn0;
    t_gpr_id  src2_gpr_rn0;
    logic     alloc_ready_ra0;
    logic     rename_ready_rn0;
    logic     wb_en_ro0   [num_wb-1:0];
    t_prf_id  wb_preg_ro0 [num_wb-1:0];
    logic     reclaim_en_rb1;
    t_prf_id  reclaim_preg_rb1;
    logic     valid_rn1;
    logic     pdst_vld_rn1;
    t_prf_id  pdst_rn1;
    t_prf_id  pdst_old_rn1;
    t_prf_id  psrc1_rn1;
    t_prf_id  psrc2_rn1;
    logic     psrc1_pend_rn1;
    logic     psrc2_pend_rn1;

    int       vals [$];                             // 23 columns per case, flattened
    int       case_line [$];                        // Text line of each case
    int       num_cases;
    int       cycles;
    int       cycle_limit;

    clock_gen clock_gen_inst (.clk, .reset);

    rename rename_inst (.*);

    // ========================================
    // Cases file
    // ========================================

    task automatic read_cases();
        int    fd;
        int    n;
        int    line_no;
        int    f [23];
        string line;
        fd = $fopen("tests/rename_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/rename_cases.txt");
            $display("Finished with errors");
            $fatal(1, "Missing cases file");
        end
        line_no = 0;
        while ($fgets(line, fd) > 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;                           // Blank or comment
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                        f[20], f[21], f[22]);
            if (n != 23) begin
                $display("Line %0d of the cases file does not hold 23 numbers", line_no);
                $display("Finished with errors");
                $fatal(1, "Malformed cases file");
            end
            foreach (f[k]) begin
                vals.push_back(f[k]);
            end
            case_line.push_back(line_no);
        end
        $fclose(fd);
        num_cases = case_line.size();
    endtask

    // ========================================
    // Drive and check
    // ========================================

    task automatic apply_case(input int b);
        valid_rn0        <= (vals[b] != 0);
        dst_type_rn0     <= t_optype'(vals[b+1]);
        dst_gpr_rn0      <= t_gpr_id'(vals[b+2]);
        src1_type_rn0    <= t_optype'(vals[b+3]);
        src1_gpr_rn0     <= t_gpr_id'(vals[b+4]);
        src2_type_rn0    <= t_optype'(vals[b+5]);
        src2_gpr_rn0     <= t_gpr_id'(vals[b+6]);
        alloc_ready_ra0  <= (vals[b+7] != 0);
        wb_en_ro0[0]     <= (vals[b+8] != 0);
        wb_preg_ro0[0]   <= t_prf_id'(vals[b+9]);
        wb_en_ro0[1]     <= (vals[b+10] != 0);
        wb_preg_ro0[1]   <= t_prf_id'(vals[b+11]);
        reclaim_en_rb1   <= (vals[b+12] != 0);
        reclaim_preg_rb1 <= t_prf_id'(vals[b+13]);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input int expected, input int line_no);
        assert (got === expected) else begin
            $display("** Error at %0t ns: cases line %0d, %s is %0d, expected %0d",
                     $time, line_no, name, got, expected);
            $display("Finished with errors");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic check_case(input int i);
        int b;
        int ln;
        b  = i * 23;
        ln = case_line[i];
        check_field("valid_rn1", 32'(valid_rn1), vals[b+14], ln);
        check_field("rename_ready_rn0", 32'(rename_ready_rn0), vals[b+22], ln);
        if (vals[b+14] != 0) begin                  // Fields only mean something with valid
            check_field("pdst_vld_rn1", 32'(pdst_vld_rn1), vals[b+15], ln);
            check_field("pdst_rn1", 32'(pdst_rn1), vals[b+16], ln);
            check_field("pdst_old_rn1", 32'(pdst_old_rn1), vals[b+17], ln);
            check_field("psrc1_rn1", 32'(psrc1_rn1), vals[b+18], ln);
            check_field("psrc1_pend_rn1", 32'(psrc1_pend_rn1), vals[b+19], ln);
            check_field("psrc2_rn1", 32'(psrc2_rn1), vals[b+20], ln);
            check_field("psrc2_pend_rn1", 32'(psrc2_pend_rn1), vals[b+21], ln);
        end
    endtask

    initial begin
        valid_rn0        = 1'b0;
        dst_type_rn0     = op_none;
        dst_gpr_rn0      = '0;
        src1_type_rn0    = op_none;
        src1_gpr_rn0     = '0;
        src2_type_rn0    = op_none;
        src2_gpr_rn0     = '0;
        alloc_ready_ra0  = 1'b0;
        reclaim_en_rb1   = 1'b0;
        reclaim_preg_rb1 = '0;
        for (int p = 0; p < num_wb; p++) begin
            wb_en_ro0[p]   = 1'b0;
            wb_preg_ro0[p] = '0;
        end
        cycles      = 0;
        cycle_limit = 100;
        read_cases();
        if (num_cases == 0) begin
            $display("The cases file holds no cases");
            $display("Finished with errors");
            $fatal(1, "Empty cases file");
        end
        cycle_limit = 4 * num_cases + 100;

        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        // Case i goes in this cycle, case i-1 shows up in rn1
        for (int i = 0; i <= num_cases; i++) begin
            if (i < num_cases) begin
                apply_case(i * 23);
            end else begin
                valid_rn0      <= 1'b0;
                wb_en_ro0[0]   <= 1'b0;
                wb_en_ro0[1]   <= 1'b0;
                reclaim_en_rb1 <= 1'b0;
            end
            if (i > 0) begin
                @(negedge clk);                     // Mid cycle, outputs settled
                check_case(i - 1);
            end
            @(posedge clk);
        end
        $display("Finished with no errors");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $fatal(1, "Timeout");
        end
    end

endmodule

//--- tests/rename_cases.txt
# valid dst_t dst src1_t src1 src2_t src2 alloc_rdy wb0_en wb0 wb1_en wb1 rcl_en rcl (t: 0 none 1 reg 2 imm)
# then rn1: valid pdst_vld pdst pdst_old psrc1 pend1 psrc2 pend2 rename_ready (fields unchecked if valid 0)
0 0 0 0 0 0 0 1 0 0 0 0 0 0    0 0 0 0 0 0 0 0 1
1 0 0 1 5 1 7 1 0 0 0 0 0 0    1 0 0 0 5 0 7 0 1
1 1 1 1 2 2 0 1 0 0 0 0 0 0    1 1 32 1 2 0 0 0 1
1 1 2 1 1 1 2 1 0 0 0 0 0 0    1 1 33 2 32 1 2 0 1
1 1 0 1 1 0 0 1 0 0 0 0 0 0    1 0 0 0 32 0 0 0 1
1 1 3 1 1 1 2 1 1 32 0 0 0 0   1 1 34 3 32 0 33 1 1
1 1 4 1 3 2 0 0 0 0 0 0 0 0    0 0 0 0 0 0 0 0 1
1 1 4 1 3 2 0 1 0 0 0 0 0 0    1 1 35 4 34 1 0 0 1
1 1 5 1 4 0 0 1 0 0 0 0 0 0    1 1 36 5 35 1 0 0 1
1 1 6 1 5 0 0 1 0 0 0 0 0 0    1 1 37 6 36 1 0 0 1
1 1 7 1 6 0 0 1 0 0 0 0 0 0    1 1 38 7 37 1 0 0 1
1 1 8 1 7 0 0 1 0 0 0 0 0 0    1 1 39 8 38 1 0 0 1
1 1 9 1 8 0 0 1 0 0 0 0 0 0    1 1 40 9 39 1 0 0 1
1 1 10 1 9 0 0 1 0 0 0 0 0 0   1 1 41 10 40 1 0 0 1
1 1 11 1 10 0 0 1 0 0 0 0 0 0  1 1 42 11 41 1 0 0 1
1 1 12 1 11 0 0 1 0 0 0 0 0 0  1 1 43 12 42 1 0 0 1
1 1 13 1 12 0 0 1 0 0 0 0 0 0  1 1 44 13 43 1 0 0 1
1 1 14 1 13 0 0 1 0 0 0 0 0 0  1 1 45 14 44 1 0 0 1
1 1 15 1 14 0 0 1 0 0 0 0 0 0  1 1 46 15 45 1 0 0 1
1 1 16 1 15 0 0 1 0 0 0 0 0 0  1 1 47 16 46 1 0 0 1
1 1 17 1 16 0 0 1 0 0 0 0 0 0  1 1 48 17 47 1 0 0 1
1 1 18 1 17 0 0 1 0 0 0 0 0 0  1 1 49 18 48 1 0 0 1
1 1 19 1 18 0 0 1 0 0 0 0 0 0  1 1 50 19 49 1 0 0 1
1 1 20 1 19 0 0 1 0 0 0 0 0 0  1 1 51 20 50 1 0 0 1
1 1 21 1 20 0 0 1 0 0 0 0 0 0  1 1 52 21 51 1 0 0 1
1 1 22 1 21 0 0 1 0 0 0 0 0 0  1 1 53 22 52 1 0 0 1
1 1 23 1 22 0 0 1 0 0 0 0 0 0  1 1 54 23 53 1 0 0 1
1 1 24 1 23 0 0 1 0 0 0 0 0 0  1 1 55 24 54 1 0 0 1
1 1 25 1 24 0 0 1 0 0 0 0 0 0  1 1 56 25 55 1 0 0 1
1 1 26 1 25 0 0 1 0 0 0 0 0 0  1 1 57 26 56 1 0 0 1
1 1 27 1 26 0 0 1 0 0 0 0 0 0  1 1 58 27 57 1 0 0 1
1 1 28 1 27 0 0 1 0 0 0 0 0 0  1 1 59 28 58 1 0 0 1
1 1 29 1 28 0 0 1 0 0 0 0 0 0  1 1 60 29 59 1 0 0 1
1 1 30 1 29 0 0 1 0 0 0 0 0 0  1 1 61 30 60 1 0 0 1
1 1 31 1 30 0 0 1 0 0 0 0 0 0  1 1 62 31 61 1 0 0 1
1 1 1 1 31 0 0 1 0 0 0 0 0 0   1 1 63 32 62 0 0 0 0
1 1 2 1 2 0 0 1 0 0 1 62 0 0   0 0 0 0 0 0 0 0 0
1 1 2 1 2 0 0 1 0 0 0 0 1 2    0 0 0 0 0 0 0 0 1
1 1 2 1 2 0 0 1 0 0 0 0 1 1    1 1 2 33 33 1 0 0 1
1 1 6 0 0 1 2 1 0 0 0 0 0 0    1 1 1 37 0 0 2 1 0

//--- rename.f
common/rename_pkg.sv
rename/rename_ctl.sv
rename/rename_rat.sv
rename/rename_free_list.sv
rename/rename.sv
tests/clock_gen.sv
tests/rename_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= rename.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
